// ==== verilog/scope_cfg.svh ====
`ifndef SCOPE_CFG_SVH
`define SCOPE_CFG_SVH

// 640x480 at one pixel per clock
`define H_ACTIVE 640    // Visible columns
`define H_FRONT 16      // Pixels before hsync
`define H_SYNC 96       // Hsync pulse width
`define H_BACK 48       // Pixels after hsync

`define V_ACTIVE 480    // Visible lines
`define V_FRONT 10      // Lines before vsync
`define V_SYNC 2        // Vsync pulse width
`define V_BACK 33       // Lines after vsync

// Trace scaling and placement
`define AXIS_ROW 240    // Zero line of the waveform
`define SAMPLE_SHIFT 8  // 16-bit sample down to +-128 rows

// Drawing levels
`define TRACE_G 8'hff     // Trace green
`define AXIS_LEVEL 8'h40  // Axis grey, all channels

`endif

// ==== verilog/scope_pkg.sv ====
package scope_pkg;

  typedef logic signed [15:0] sample_t;  // Codec sample, two's complement
  typedef logic [8:0] row_t;             // Screen row
  typedef logic [9:0] col_t;             // Screen column

  // One column of the trace, capture to buffer
  typedef struct packed {
    col_t col;  // Target column
    row_t row;  // Row the trace sits on
  } col_write_t;

  // Raster position for the current clock
  typedef struct packed {
    col_t x;       // Horizontal count
    row_t y;       // Vertical count, low bits
    logic active;  // Inside the visible area
    logic hsync;   // Pin polarity, low in pulse
    logic vsync;   // Pin polarity, low in pulse
  } vga_pos_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  typedef enum logic {
    CAP_ARMED,    // Waiting for a rising zero crossing
    CAP_FILLING   // Writing columns 1 to 639
  } capture_state_t;

endpackage

// ==== verilog/sample_capture.sv ====
`timescale 1ns/1ps
`include "scope_cfg.svh"

module sample_capture (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  sample_valid,  // One-cycle strobe
  input  scope_pkg::sample_t    sample,
  input  logic                  freeze,        // Blocks new triggers only
  output logic                  wr_valid,      // One column per strobe
  output scope_pkg::col_write_t wr
);
  import scope_pkg::*;

  localparam col_t LAST_COL = col_t'(`H_ACTIVE - 1);

  capture_state_t state;
  sample_t        prev_sample;  // Last strobed sample
  col_t           col;          // Next column to write
  logic           crossing;
  sample_t        scaled;
  sample_t        row_full;
  row_t           sample_row;

  // Previous negative, current at or above zero
  assign crossing = prev_sample[15] && !sample[15];

  assign scaled     = sample >>> `SAMPLE_SHIFT;            // Range -128..127
  assign row_full   = sample_t'(`AXIS_ROW) - scaled;       // Positive goes up
  assign sample_row = row_t'(row_full);                    // 113..368, fits 9 bits

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= CAP_ARMED;
      prev_sample <= '0;
      col         <= '0;
      wr_valid    <= 1'b0;
    end else begin
      wr_valid <= 1'b0;  // Strobe by default off
      if (sample_valid) begin
        prev_sample <= sample;
        case (state)
          CAP_ARMED: begin
            if (crossing && !freeze) begin  // Trigger sample lands in column 0
              wr_valid <= 1'b1;
              col      <= col_t'(1);
              state    <= CAP_FILLING;
            end
          end
          CAP_FILLING: begin
            wr_valid <= 1'b1;
            if (col == LAST_COL) begin  // Screen full, rearm
              col   <= '0;
              state <= CAP_ARMED;
            end else begin
              col <= col + col_t'(1);
            end
          end
          default: state <= CAP_ARMED;
        endcase
      end
    end
  end

  // Payload, qualified by wr_valid
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      wr.col <= col;  // Zero while armed
      wr.row <= sample_row;
    end
  end

  // Write strobe always follows an input strobe by one cycle
  assert property (@(posedge clk) disable iff (reset) wr_valid |-> $past(sample_valid));

  // Column counter stays on screen
  assert property (@(posedge clk) disable iff (reset) col <= LAST_COL);

endmodule

// ==== verilog/trace_buffer.sv ====
`timescale 1ns/1ps
`include "scope_cfg.svh"

module trace_buffer (
  input  logic                  clk,
  input  logic                  wr_valid,
  input  scope_pkg::col_write_t wr,
  input  scope_pkg::col_t       rd_col,  // From the pixel pipeline
  output scope_pkg::row_t       rd_row   // One cycle after rd_col
);
  import scope_pkg::*;

  localparam col_t DEPTH = col_t'(`H_ACTIVE);

  row_t mem [0:`H_ACTIVE-1];  // One trace row per screen column
  logic rd_en;

  // Blanking columns 640..799 skip the read
  assign rd_en = rd_col < DEPTH;

  // Write port, old columns kept until overwritten
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr.col] <= wr.row;
    end
  end

  // Read-first port, same-cycle write not visible
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_row <= mem[rd_col];
    end
  end

  // Capture side never addresses past the screen
  assert property (@(posedge clk) wr_valid |-> wr.col < DEPTH);

endmodule

// ==== verilog/vga_timing.sv ====
`timescale 1ns/1ps
`include "scope_cfg.svh"

module vga_timing (
  input  logic                clk,
  input  logic                reset,
  output scope_pkg::vga_pos_t pos  // Valid every cycle
);
  import scope_pkg::*;

  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;  // 800
  localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;  // 525

  localparam logic [9:0] H_LAST    = 10'(H_TOTAL - 1);
  localparam logic [9:0] V_LAST    = 10'(V_TOTAL - 1);
  localparam logic [9:0] H_VIS     = 10'(`H_ACTIVE);
  localparam logic [9:0] V_VIS     = 10'(`V_ACTIVE);
  localparam logic [9:0] HS_START  = 10'(`H_ACTIVE + `H_FRONT);             // 656
  localparam logic [9:0] HS_END    = 10'(`H_ACTIVE + `H_FRONT + `H_SYNC);   // 752
  localparam logic [9:0] VS_START  = 10'(`V_ACTIVE + `V_FRONT);             // 490
  localparam logic [9:0] VS_END    = 10'(`V_ACTIVE + `V_FRONT + `V_SYNC);   // 492
  localparam logic [9:0] H_LIMIT   = 10'(H_TOTAL);

  logic [9:0] h_count;  // 0..799
  logic [9:0] v_count;  // 0..524, wider than a row

  always_ff @(posedge clk) begin
    if (reset) begin
      h_count <= '0;
      v_count <= '0;
    end else if (h_count == H_LAST) begin  // End of line
      h_count <= '0;
      if (v_count == V_LAST) begin         // End of frame
        v_count <= '0;
      end else begin
        v_count <= v_count + 10'd1;
      end
    end else begin
      h_count <= h_count + 10'd1;
    end
  end

  // Position and flags straight from the counters
  always_comb begin
    pos.x      = h_count;
    pos.y      = row_t'(v_count);  // Aliases only in vertical blanking
    pos.active = (h_count < H_VIS) && (v_count < V_VIS);
    pos.hsync  = !((h_count >= HS_START) && (h_count < HS_END));  // Active low
    pos.vsync  = !((v_count >= VS_START) && (v_count < VS_END));  // Active low
  end

  // Line counter wraps before the total
  assert property (@(posedge clk) disable iff (reset) h_count < H_LIMIT);

endmodule

// ==== verilog/trace_render.sv ====
`timescale 1ns/1ps
`include "scope_cfg.svh"

module trace_render (
  input  logic                clk,
  input  logic                reset,
  input  scope_pkg::vga_pos_t pos,
  output scope_pkg::col_t     rd_col,   // Buffer read address
  input  scope_pkg::row_t     rd_row,   // Trace row for last rd_col
  output scope_pkg::rgb_t     pixel,
  output logic                hsync,
  output logic                vsync,
  output logic                blank_n   // High on visible pixels
);
  import scope_pkg::*;

  localparam row_t AXIS = row_t'(`AXIS_ROW);

  row_t s1_y;       // Row, lined up with rd_row
  logic s1_active;
  logic s1_hsync;
  logic s1_vsync;
  rgb_t colour;     // Stage 2 decision

  // Stage 1 read goes straight to the buffer
  assign rd_col = pos.x;

  always_ff @(posedge clk) begin
    s1_y <= pos.y;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_active <= 1'b0;
      s1_hsync  <= 1'b1;
      s1_vsync  <= 1'b1;
    end else begin
      s1_active <= pos.active;
      s1_hsync  <= pos.hsync;
      s1_vsync  <= pos.vsync;
    end
  end

  // Trace over axis over black
  always_comb begin
    colour = '0;
    if (s1_active) begin
      if (rd_row == s1_y) begin
        colour.g = `TRACE_G;
      end else if (s1_y == AXIS) begin
        colour = '{r: `AXIS_LEVEL, g: `AXIS_LEVEL, b: `AXIS_LEVEL};
      end
    end
  end

  // Stage 2 output registers, two cycles behind pos
  always_ff @(posedge clk) begin
    if (reset) begin
      pixel   <= '0;
      hsync   <= 1'b1;
      vsync   <= 1'b1;
      blank_n <= 1'b0;
    end else begin
      pixel   <= colour;
      hsync   <= s1_hsync;
      vsync   <= s1_vsync;
      blank_n <= s1_active;
    end
  end

  // Sync pulses never overlap visible pixels
  assert property (@(posedge clk) disable iff (reset) blank_n |-> (hsync && vsync));

endmodule

// ==== verilog/scope_view.sv ====
`timescale 1ns/1ps

module scope_view (
  input  logic               clk,
  input  logic               reset,
  input  logic               sample_valid,  // Codec sample strobe
  input  scope_pkg::sample_t sample,
  input  logic               freeze,        // Hold the current trace
  output scope_pkg::rgb_t    pixel,
  output logic               hsync,
  output logic               vsync,
  output logic               blank_n
);
  import scope_pkg::*;

  logic       wr_valid;  // Capture to buffer
  col_write_t wr;
  vga_pos_t   pos;       // Raster position
  col_t       rd_col;    // Render to buffer
  row_t       rd_row;    // Buffer to render

  sample_capture u_capture (
    .clk          (clk),
    .reset        (reset),
    .sample_valid (sample_valid),
    .sample       (sample),
    .freeze       (freeze),
    .wr_valid     (wr_valid),
    .wr           (wr)
  );

  trace_buffer u_buffer (
    .clk      (clk),
    .wr_valid (wr_valid),
    .wr       (wr),
    .rd_col   (rd_col),
    .rd_row   (rd_row)
  );

  vga_timing u_timing (
    .clk   (clk),
    .reset (reset),
    .pos   (pos)
  );

  trace_render u_render (
    .clk     (clk),
    .reset   (reset),
    .pos     (pos),
    .rd_col  (rd_col),
    .rd_row  (rd_row),
    .pixel   (pixel),
    .hsync   (hsync),
    .vsync   (vsync),
    .blank_n (blank_n)
  );

endmodule

// ==== test/scope_view_tb.sv ====
`timescale 1ns/1ps
`include "scope_cfg.svh"

module scope_view_tb;
  import scope_pkg::*;

  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int FRAME_CYCLES = H_TOTAL * (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK);

  logic        clk;
  logic        reset;
  logic        sample_valid;
  sample_t     sample;
  logic        freeze;
  rgb_t        pixel;
  logic        hsync;
  logic        vsync;
  logic        blank_n;
  logic [31:0] lfsr;                   // Galois LFSR state
  int          model_row [0:`H_ACTIVE-1];  // Expected trace row per column
  int          green_row [0:`H_ACTIVE-1];  // Scanned trace row per column
  int          green_cnt [0:`H_ACTIVE-1];  // Green pixels seen per column
  bit          m_filling;              // Model capture state
  int          m_col;
  int          m_prev;                 // Model previous sample

  scope_view DUT (.clk(clk), .reset(reset), .sample_valid(sample_valid), .sample(sample),
                  .freeze(freeze), .pixel(pixel), .hsync(hsync), .vsync(vsync),
                  .blank_n(blank_n));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t %s got %0h expected %0h", $time, name, got, exp));
    end
  endtask

  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);  // x^32+x^22+x^2+x+1
  endfunction

  function automatic sample_t random_sample();
    sample_t s;
    for (int i = 0; i < 16; i++) begin
      s[i] = lfsr[0];        // One step per bit
      lfsr = next_lfsr(lfsr);
    end
    return s;
  endfunction

  // Axis minus the scaled sample
  function automatic int row_of(input sample_t s);
    int v;
    v = s;
    return `AXIS_ROW - (v >>> `SAMPLE_SHIFT);
  endfunction

  // Capture rules applied to the expected row array
  task automatic model_strobe(input sample_t s, input logic frz);
    if (!m_filling) begin
      if (m_prev < 0 && s >= 0 && !frz) begin  // Rising zero crossing
        model_row[0] = row_of(s);
        m_col = 1;
        m_filling = 1'b1;
      end
    end else begin
      model_row[m_col] = row_of(s);
      if (m_col == `H_ACTIVE - 1) begin  // Rearm after the last column
        m_col = 0;
        m_filling = 1'b0;
      end else begin
        m_col++;
      end
    end
    m_prev = s;
  endtask

  // One strobe and three idle cycles
  task automatic send_sample(input sample_t s);
    @(posedge clk);
    sample_valid <= 1'b1;
    sample <= s;
    model_strobe(s, freeze);
    @(posedge clk);
    sample_valid <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  // Negative lead-in and a full screen starting on a crossing
  task automatic fill_trace();
    sample_t s;
    send_sample(16'sh8a00);
    for (int i = 0; i < `H_ACTIVE; i++) begin
      s = random_sample();
      if (i == 0 || i == `H_ACTIVE - 1) s[15] = 1'b0;  // Ends at or above zero too
      send_sample(s);
    end
  endtask

  // One frame from vsync fall to vsync fall, sampled at negedge
  task automatic scan_frame();
    int t;
    int rows;
    int cols;
    int hs_low;
    logic prev_vs;
    logic prev_bn;
    logic prev_hs;
    logic fell;
    for (int c = 0; c < `H_ACTIVE; c++) begin
      green_row[c] = -1;
      green_cnt[c] = 0;
    end
    t = 0;
    prev_vs = vsync;
    do begin
      @(negedge clk);
      fell = prev_vs && !vsync;
      prev_vs = vsync;
      t++;
      if (t > FRAME_CYCLES + H_TOTAL) abort_run("Timed out waiting for vsync to fall");
    end while (!fell);
    t = 0;
    rows = 0;
    cols = 0;
    hs_low = 0;
    prev_bn = blank_n;
    prev_hs = hsync;
    do begin
      @(negedge clk);
      t++;
      if (t > FRAME_CYCLES + H_TOTAL) abort_run("Timed out scanning a frame");
      if (blank_n && !prev_bn) cols = 0;  // Line start
      if (!blank_n && prev_bn) begin      // Line end
        check("line length", cols, `H_ACTIVE);
        rows++;
      end
      if (!hsync) hs_low++;               // Inside an hsync pulse
      if (hsync && !prev_hs) begin        // Pulse just ended
        check("hsync width", hs_low, `H_SYNC);
        hs_low = 0;
      end
      if (blank_n && cols < `H_ACTIVE && rows < `V_ACTIVE) begin
        if (pixel.g == `TRACE_G) begin
          check("trace pixel", 32'(pixel), 32'({8'h00, `TRACE_G, 8'h00}));
          green_cnt[cols]++;
          green_row[cols] = rows;
        end else if (rows == `AXIS_ROW) begin
          check("axis pixel", 32'(pixel), 32'({`AXIS_LEVEL, `AXIS_LEVEL, `AXIS_LEVEL}));
        end else begin
          check("background pixel", 32'(pixel), 0);
        end
      end
      if (blank_n) cols++;
      fell = prev_vs && !vsync;
      prev_vs = vsync;
      prev_bn = blank_n;
      prev_hs = hsync;
    end while (!fell);
    check("line count", rows, `V_ACTIVE);
  endtask

  // Exactly one green pixel per column on the model row
  task automatic compare_frame();
    scan_frame();
    for (int c = 0; c < `H_ACTIVE; c++) begin
      check($sformatf("green count col %0d", c), green_cnt[c], 1);
      check($sformatf("trace row col %0d", c), green_row[c], model_row[c]);
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);  // Before the first pixel leaves the pipeline
    check("hsync", 32'(hsync), 1);
    check("vsync", 32'(vsync), 1);
    check("blank_n", 32'(blank_n), 0);
    check("pixel", 32'(pixel), 0);
  endtask

  task automatic test_capture();
    fill_trace();
    compare_frame();
  endtask

  task automatic test_no_trigger();
    for (int i = 0; i < 16; i++) send_sample(16'(100 + i * 1500));  // All positive
    compare_frame();
  endtask

  task automatic test_freeze();
    sample_t s;
    @(posedge clk);
    freeze <= 1'b1;
    for (int i = 0; i < 8; i++) begin  // Crossings that must be ignored
      s = random_sample();
      s[15] = 1'b1;
      send_sample(s);
      s[15] = 1'b0;
      send_sample(s);
    end
    compare_frame();
    @(posedge clk);
    freeze <= 1'b0;
    fill_trace();
    compare_frame();
  endtask

  initial begin
    reset = 1'b1;
    sample_valid = 1'b0;
    sample = '0;
    freeze = 1'b0;
    lfsr = 32'hf7a26642;
    m_filling = 1'b0;
    m_col = 0;
    m_prev = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    scan_frame();     // Geometry and axis on the first frame
    test_capture();   // Triggered capture
    test_no_trigger();
    test_freeze();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== scope_view.f ====
+incdir+verilog
verilog/scope_pkg.sv
verilog/sample_capture.sv
verilog/trace_buffer.sv
verilog/vga_timing.sv
verilog/trace_render.sv
verilog/scope_view.sv
test/scope_view_tb.sv

// ==== Makefile ====
# Verilator build and run of the scope_view testbench
VERILATOR ?= verilator
TOP       ?= scope_view_tb
FLIST     ?= scope_view.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Build, then run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
